// File: verification/tb_periph.sv
`include "periph_params.svh"

module tb_periph
  import periph_pkg::*;
();

  localparam haddr_t SEG7_LO_ADDR =
    haddr_t'((`PERIPH_SLOT_SEG7 << `PERIPH_SLOT_LSB) + `SEG7_REG_LO);
  localparam haddr_t SEG7_HI_ADDR =
    haddr_t'((`PERIPH_SLOT_SEG7 << `PERIPH_SLOT_LSB) + `SEG7_REG_HI);
  localparam haddr_t UART_DATA_ADDR =
    haddr_t'((`PERIPH_SLOT_UART << `PERIPH_SLOT_LSB) + `UART_REG_DATA);
  localparam haddr_t UART_STAT_ADDR =
    haddr_t'((`PERIPH_SLOT_UART << `PERIPH_SLOT_LSB) + `UART_REG_STAT);
  localparam haddr_t NULL_ADDR = haddr_t'(2 << `PERIPH_SLOT_LSB);
  localparam htrans_t HTRANS_IDLE = 2'b00;

  // one display frame is load, 32 half periods of sh_clk and the latch pulse
  localparam int SEG_FRAME = 1 + 32 * `SEG7_SH_DIV + `SEG7_SH_DIV;
  localparam int UART_FRAME = 10 * `UART_BAUD_DIV;
  localparam int RUN_LIMIT = 2 * (10 * SEG_FRAME + 3 * UART_FRAME);

  logic    CLK_CM3;
  logic    arst_n;
  logic    hsel;
  haddr_t  haddr;
  htrans_t htrans;
  logic    hwrite;
  hdata_t  hwdata;
  logic    hready;
  hdata_t  hrdata;
  logic    hresp;
  logic    sh_clk;
  logic    ld_clk;
  logic    ds;
  logic    tx;

  logic [31:0] lcg_state = 32'h1c05_9e93;
  int          cycle_cnt = 0;
  int          wait_cycles;
  logic        last_resp;
  hdata_t      exp_lo;
  hdata_t      exp_hi;

  // display capture
  logic        seg_cap_on = 1'b0;
  logic        sh_prev = 1'b0;
  logic        ld_prev = 1'b0;
  logic [15:0] seg_shift;
  int          seg_bits = 0;
  logic [15:0] seg_q[$];

  // uart capture
  seg_byte_t   rx_byte;
  seg_byte_t   rx_q[$];

  periph_top i_dut (
    .CLK_CM3 (CLK_CM3),
    .arst_n  (arst_n),
    .hsel    (hsel),
    .haddr   (haddr),
    .htrans  (htrans),
    .hwrite  (hwrite),
    .hwdata  (hwdata),
    .hready  (hready),
    .hrdata  (hrdata),
    .hresp   (hresp),
    .sh_clk  (sh_clk),
    .ld_clk  (ld_clk),
    .ds      (ds),
    .tx      (tx)
  );

  initial
  begin
    CLK_CM3 = 1'b0;
    forever #10 CLK_CM3 = !CLK_CM3;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input hdata_t exp, input hdata_t act);
    if (act !== exp)
    begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      fail_run("data mismatch");
    end
  endtask

  task automatic check_byte(input string name, input seg_byte_t exp, input seg_byte_t act);
    if (act !== exp)
    begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      fail_run("byte mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      fail_run("bit mismatch");
    end
  endtask

  always @(posedge CLK_CM3)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > RUN_LIMIT)
      fail_run("timeout: the tests did not finish within the cycle limit");
  end

  // shift register model, ds taken on each rising sh_clk
  always @(negedge CLK_CM3)
  begin
    if (seg_cap_on)
    begin
      if (sh_clk && !sh_prev)
      begin
        seg_shift = {seg_shift[14:0], ds};
        seg_bits  = seg_bits + 1;
      end
      if (ld_clk && !ld_prev)
      begin
        // a frame cut short by the capture start is dropped
        if (seg_bits == 16)
          seg_q.push_back(seg_shift);
        seg_bits = 0;
      end
    end
    sh_prev = sh_clk;
    ld_prev = ld_clk;
  end

  // 8N1 receiver sampling mid-bit
  always
  begin
    @(negedge CLK_CM3);
    if (arst_n && tx === 1'b0)
    begin
      repeat (`UART_BAUD_DIV / 2) @(negedge CLK_CM3);
      check_bit("tx start bit", 1'b0, tx);
      for (int i = 0; i < 8; i++)
      begin
        repeat (`UART_BAUD_DIV) @(negedge CLK_CM3);
        rx_byte[i] = tx;
      end
      repeat (`UART_BAUD_DIV) @(negedge CLK_CM3);
      check_bit("tx stop bit", 1'b1, tx);
      rx_q.push_back(rx_byte);
    end
  end

  // called just after a rising edge, returns just after one
  task automatic bus_access(input haddr_t addr, input logic write, input hdata_t wdata,
                            output hdata_t rdata);
    logic ready;
    hsel   = 1'b1;
    haddr  = addr;
    htrans = `PERIPH_HTRANS_NONSEQ;
    hwrite = write;
    ready  = 1'b0;
    while (!ready)
    begin
      @(negedge CLK_CM3);
      ready = hready;
      @(posedge CLK_CM3);
      #1;
    end
    // data phase
    hsel        = 1'b0;
    htrans      = HTRANS_IDLE;
    hwrite      = 1'b0;
    hwdata      = wdata;
    ready       = 1'b0;
    wait_cycles = 0;
    while (!ready)
    begin
      @(negedge CLK_CM3);
      ready     = hready;
      rdata     = hrdata;
      last_resp = hresp;
      if (!ready)
        wait_cycles = wait_cycles + 1;
      @(posedge CLK_CM3);
      #1;
    end
  endtask

  task automatic ahb_write(input haddr_t addr, input hdata_t data);
    hdata_t unused;
    bus_access(addr, 1'b1, data, unused);
  endtask

  task automatic ahb_read(input haddr_t addr, output hdata_t data);
    bus_access(addr, 1'b0, '0, data);
  endtask

  task automatic wait_rx(input int n);
    while (rx_q.size() < n)
      @(posedge CLK_CM3);
    #1;
  endtask

  task automatic test_reset();
    hdata_t rd;
    repeat (2) @(posedge CLK_CM3);
    @(negedge CLK_CM3);
    check_bit("tx", 1'b1, tx);
    check_bit("sh_clk", 1'b0, sh_clk);
    check_bit("ld_clk", 1'b0, ld_clk);
    check_bit("ds", 1'b0, ds);
    check_bit("hready", 1'b1, hready);
    @(posedge CLK_CM3);
    #1;
    arst_n = 1'b1;
    ahb_read(SEG7_LO_ADDR, rd);
    check_data("seg7 low register", '0, rd);
    ahb_read(SEG7_HI_ADDR, rd);
    check_data("seg7 high register", '0, rd);
  endtask

  task automatic test_registers();
    hdata_t rd;
    exp_lo = next_random();
    exp_hi = next_random();
    ahb_write(SEG7_LO_ADDR, exp_lo);
    ahb_write(SEG7_HI_ADDR, exp_hi);
    ahb_read(SEG7_LO_ADDR, rd);
    check_data("seg7 low register", exp_lo, rd);
    ahb_read(SEG7_HI_ADDR, rd);
    check_data("seg7 high register", exp_hi, rd);
    ahb_read(NULL_ADDR, rd);
    check_data("null slot hrdata", '0, rd);
    check_bit("hresp", 1'b0, last_resp);
  endtask

  task automatic test_display();
    logic [63:0] digits;
    logic [15:0] fr;
    int          k0;
    int          k;
    digits     = {exp_hi, exp_lo};
    seg_bits   = 0;
    seg_q.delete();
    seg_cap_on = 1'b1;
    while (seg_q.size() < 8)
      @(posedge CLK_CM3);
    #1;
    seg_cap_on = 1'b0;
    k0 = -1;
    for (int b = 0; b < 8; b++)
      if (seg_q[0][7:0] == seg_byte_t'(8'd1 << b))
        k0 = b;
    if (k0 < 0)
      fail_run("digit select byte of the first display frame is not one-hot");
    // frames must walk through the digits in order
    for (int i = 0; i < 8; i++)
    begin
      fr = seg_q[i];
      k  = (k0 + i) % 8;
      check_byte("digit select", seg_byte_t'(8'd1 << k), fr[7:0]);
      check_byte("segment byte", digits[k*8 +: 8], fr[15:8]);
    end
  endtask

  task automatic test_uart_single();
    logic [31:0] r;
    hdata_t      rd;
    r = next_random();
    rx_q.delete();
    ahb_write(UART_DATA_ADDR, {24'b0, r[7:0]});
    ahb_read(UART_STAT_ADDR, rd);
    check_data("uart status during frame", 32'd1, rd);
    wait_rx(1);
    check_byte("uart byte", r[7:0], rx_q[0]);
    repeat (`UART_BAUD_DIV) @(posedge CLK_CM3);
    #1;
    ahb_read(UART_STAT_ADDR, rd);
    check_data("uart status after frame", 32'd0, rd);
  endtask

  task automatic test_uart_back_to_back();
    logic [31:0] r1;
    logic [31:0] r2;
    hdata_t      rd;
    r1 = next_random();
    r2 = next_random();
    rx_q.delete();
    ahb_write(UART_DATA_ADDR, {24'b0, r1[7:0]});
    ahb_write(UART_DATA_ADDR, {24'b0, r2[7:0]});
    check_bit("hready stall on second write", 1'b1, wait_cycles > 0);
    // second write only completes once the first frame is out
    check_data("bytes received at second write", 32'd1, hdata_t'(rx_q.size()));
    wait_rx(2);
    check_byte("first uart byte", r1[7:0], rx_q[0]);
    check_byte("second uart byte", r2[7:0], rx_q[1]);
    ahb_read(UART_DATA_ADDR, rd);
    check_data("uart data register", {24'b0, r2[7:0]}, rd);
  endtask

  initial
  begin
    arst_n = 1'b0;
    hsel   = 1'b0;
    haddr  = '0;
    htrans = HTRANS_IDLE;
    hwrite = 1'b0;
    hwdata = '0;
    test_reset();
    test_registers();
    test_display();
    test_uart_single();
    test_uart_back_to_back();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: verilog/ahb_decoder.sv
`include "periph_params.svh"

module ahb_decoder
  import periph_pkg::*;
(
  input  logic    CLK_CM3,
  input  logic    arst_n,
  input  logic    hsel,
  input  haddr_t  haddr,
  input  htrans_t htrans,
  output logic    hready_out,
  input  hdata_t  seg7_rdata,
  input  logic    seg7_ready,
  input  hdata_t  uart_rdata,
  input  logic    uart_ready,
  output logic    sel_seg7,
  output logic    sel_uart,
  output hdata_t  hrdata,
  output logic    hresp
);

  // slots 2 and 3 and idle data phases all land here
  localparam slot_t SLOT_NULL = 2'd3;

  slot_t addr_slot;
  slot_t dp_slot;
  logic  accept;

  // address phase decode
  assign addr_slot = haddr[`PERIPH_SLOT_LSB +: 2];
  assign sel_seg7  = hsel && (addr_slot == slot_t'(`PERIPH_SLOT_SEG7));
  assign sel_uart  = hsel && (addr_slot == slot_t'(`PERIPH_SLOT_UART));

  assign accept = hsel && (htrans == `PERIPH_HTRANS_NONSEQ) && hready_out;

  // remember who owns the next data phase
  always_ff @(posedge CLK_CM3 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      dp_slot <= SLOT_NULL;
    end
    else if (hready_out)
    begin
      if (accept)
        dp_slot <= addr_slot;
      else
        dp_slot <= SLOT_NULL;
    end
  end

  // response steering
  always_comb
  begin
    hrdata     = '0;
    hready_out = 1'b1;
    if (dp_slot == slot_t'(`PERIPH_SLOT_SEG7))
    begin
      hrdata     = seg7_rdata;
      hready_out = seg7_ready;
    end
    else if (dp_slot == slot_t'(`PERIPH_SLOT_UART))
    begin
      hrdata     = uart_rdata;
      hready_out = uart_ready;
    end
  end

  // no error responses on this bus
  assign hresp = 1'b0;

  // a stalled data phase always belongs to the uart
  a_stall_from_uart : assert property (
    @(posedge CLK_CM3) disable iff (!arst_n)
    !hready_out |-> (dp_slot == slot_t'(`PERIPH_SLOT_UART))
  );

endmodule

// File: verilog/periph_params.svh
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// offset bits seen by the peripherals
`define PERIPH_ADDR_W 16

// slot field sits just above the register offsets
`define PERIPH_SLOT_LSB 12
`define PERIPH_SLOT_SEG7 0
`define PERIPH_SLOT_UART 1

// htrans encoding, single transfers only
`define PERIPH_HTRANS_NONSEQ 2'b10

// display registers, byte k drives digit k
`define SEG7_REG_LO 0
`define SEG7_REG_HI 4

// system clocks per half period of sh_clk
`define SEG7_SH_DIV 2

// uart registers
`define UART_REG_DATA 0
`define UART_REG_STAT 4

// system clocks per bit
`define UART_BAUD_DIV 8

`endif

// File: verilog/periph_pkg.sv
`include "periph_params.svh"

package periph_pkg;

  // bus offset as seen below the decoder
  typedef logic [`PERIPH_ADDR_W-1:0] haddr_t;

  // bus data
  typedef logic [31:0] hdata_t;

  // transfer type
  typedef logic [1:0] htrans_t;

  // slot index out of the decoder
  typedef logic [1:0] slot_t;

  // one segment or digit-select byte
  typedef logic [7:0] seg_byte_t;

  // display shift-out sequence
  typedef enum logic [1:0] {
    LOAD,
    SHIFT,
    LATCH
  } seg7_state_t;

  // 8N1 transmit frame
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_t;

endpackage

// File: verilog/periph_top.sv
`include "periph_params.svh"

module periph_top
  import periph_pkg::*;
(
  input  logic    CLK_CM3,
  input  logic    arst_n,
  input  logic    hsel,
  input  haddr_t  haddr,
  input  htrans_t htrans,
  input  logic    hwrite,
  input  hdata_t  hwdata,
  output logic    hready,
  output hdata_t  hrdata,
  output logic    hresp,
  output logic    sh_clk,
  output logic    ld_clk,
  output logic    ds,
  output logic    tx
);

  logic   sel_seg7;
  logic   sel_uart;
  hdata_t seg7_rdata;
  logic   seg7_ready;
  hdata_t uart_rdata;
  logic   uart_ready;

  ahb_decoder i_decoder (
    .CLK_CM3    (CLK_CM3),
    .arst_n     (arst_n),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hready_out (hready),
    .seg7_rdata (seg7_rdata),
    .seg7_ready (seg7_ready),
    .uart_rdata (uart_rdata),
    .uart_ready (uart_ready),
    .sel_seg7   (sel_seg7),
    .sel_uart   (sel_uart),
    .hrdata     (hrdata),
    .hresp      (hresp)
  );

  // display on slot 0
  seg7_scanner i_seg7 (
    .CLK_CM3  (CLK_CM3),
    .arst_n   (arst_n),
    .sel      (sel_seg7),
    .haddr    (haddr),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .hwdata   (hwdata),
    .hready   (hready),
    .rdata    (seg7_rdata),
    .readyout (seg7_ready),
    .sh_clk   (sh_clk),
    .ld_clk   (ld_clk),
    .ds       (ds)
  );

  // uart on slot 1
  uart_tx i_uart (
    .CLK_CM3  (CLK_CM3),
    .arst_n   (arst_n),
    .sel      (sel_uart),
    .haddr    (haddr),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .hwdata   (hwdata),
    .hready   (hready),
    .rdata    (uart_rdata),
    .readyout (uart_ready),
    .tx       (tx)
  );

endmodule

// File: verilog/seg7_scanner.sv
`include "periph_params.svh"

module seg7_scanner
  import periph_pkg::*;
(
  input  logic    CLK_CM3,
  input  logic    arst_n,
  input  logic    sel,
  input  haddr_t  haddr,
  input  htrans_t htrans,
  input  logic    hwrite,
  input  hdata_t  hwdata,
  input  logic    hready,
  output hdata_t  rdata,
  output logic    readyout,
  output logic    sh_clk,
  output logic    ld_clk,
  output logic    ds
);

  localparam int DIV_W = $clog2(`SEG7_SH_DIV + 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SEG7_SH_DIV - 1);

  logic        wr_pend;
  haddr_t      addr_q;
  hdata_t      disp_lo;
  hdata_t      disp_hi;
  logic [63:0] disp_all;

  seg7_state_t      state;
  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       bit_cnt;
  logic [2:0]       digit;
  logic [15:0]      frame;
  seg_byte_t        cur_seg;
  seg_byte_t        cur_sel;

  // address phase capture
  always_ff @(posedge CLK_CM3 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_pend <= 1'b0;
      addr_q  <= '0;
    end
    else if (hready)
    begin
      wr_pend <= sel && (htrans == `PERIPH_HTRANS_NONSEQ) && hwrite;
      addr_q  <= haddr;
    end
  end

  // display registers, written in the data phase
  always_ff @(posedge CLK_CM3 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      disp_lo <= '0;
      disp_hi <= '0;
    end
    else if (wr_pend && hready)
    begin
      if (addr_q[`PERIPH_SLOT_LSB-1:0] == `SEG7_REG_LO)
        disp_lo <= hwdata;
      else if (addr_q[`PERIPH_SLOT_LSB-1:0] == `SEG7_REG_HI)
        disp_hi <= hwdata;
    end
  end

  always_comb
  begin
    rdata = '0;
    if (addr_q[`PERIPH_SLOT_LSB-1:0] == `SEG7_REG_LO)
      rdata = disp_lo;
    else if (addr_q[`PERIPH_SLOT_LSB-1:0] == `SEG7_REG_HI)
      rdata = disp_hi;
  end

  assign readyout = 1'b1;

  // segment byte for the current digit, then its one-hot select
  assign disp_all = {disp_hi, disp_lo};
  assign cur_seg  = disp_all[{digit, 3'b000} +: 8];
  assign cur_sel  = seg_byte_t'(8'd1 << digit);
  assign ds       = frame[15];

  always_ff @(posedge CLK_CM3 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state   <= LOAD;
      div_cnt <= '0;
      bit_cnt <= '0;
      digit   <= '0;
      frame   <= '0;
      sh_clk  <= 1'b0;
      ld_clk  <= 1'b0;
    end
    else
    begin
      case (state)
        LOAD:
        begin
          frame   <= {cur_seg, cur_sel};
          div_cnt <= '0;
          bit_cnt <= '0;
          state   <= SHIFT;
        end
        SHIFT:
        begin
          if (div_cnt == DIV_LAST)
          begin
            div_cnt <= '0;
            sh_clk  <= !sh_clk;
            // falling edge moves the next bit onto ds
            if (sh_clk)
            begin
              frame   <= {frame[14:0], 1'b0};
              bit_cnt <= bit_cnt + 4'd1;
              if (bit_cnt == 4'd15)
              begin
                ld_clk <= 1'b1;
                state  <= LATCH;
              end
            end
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        LATCH:
        begin
          if (div_cnt == DIV_LAST)
          begin
            div_cnt <= '0;
            ld_clk  <= 1'b0;
            digit   <= digit + 3'd1;
            state   <= LOAD;
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        default:
          state <= LOAD;
      endcase
    end
  end

  a_ld_sh_exclusive : assert property (
    @(posedge CLK_CM3) disable iff (!arst_n)
    !(ld_clk && sh_clk)
  );

endmodule

// File: verilog/uart_tx.sv
`include "periph_params.svh"

module uart_tx
  import periph_pkg::*;
(
  input  logic    CLK_CM3,
  input  logic    arst_n,
  input  logic    sel,
  input  haddr_t  haddr,
  input  htrans_t htrans,
  input  logic    hwrite,
  input  hdata_t  hwdata,
  input  logic    hready,
  output hdata_t  rdata,
  output logic    readyout,
  output logic    tx
);

  localparam int BAUD_W = $clog2(`UART_BAUD_DIV + 1);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`UART_BAUD_DIV - 1);

  logic              wr_pend;
  haddr_t            addr_q;
  logic              data_wr;
  logic              busy;
  logic              start_tx;
  logic [7:0]        tx_byte;
  uart_state_t       state;
  logic [BAUD_W-1:0] baud_cnt;
  logic [2:0]        bit_cnt;
  logic              baud_end;

  always_ff @(posedge CLK_CM3 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_pend <= 1'b0;
      addr_q  <= '0;
    end
    else if (hready)
    begin
      wr_pend <= sel && (htrans == `PERIPH_HTRANS_NONSEQ) && hwrite;
      addr_q  <= haddr;
    end
  end

  assign data_wr  = wr_pend && (addr_q[`PERIPH_SLOT_LSB-1:0] == `UART_REG_DATA);
  assign busy     = (state != IDLE);
  // stall a data write until the running frame is out
  assign readyout = !(data_wr && busy);
  assign start_tx = data_wr && !busy && hready;
  assign baud_end = (baud_cnt == BAUD_LAST);

  always_ff @(posedge CLK_CM3)
  begin
    if (start_tx)
      tx_byte <= hwdata[7:0];
  end

  always_comb
  begin
    rdata = '0;
    if (addr_q[`PERIPH_SLOT_LSB-1:0] == `UART_REG_STAT)
      rdata = {31'b0, busy};
    else if (addr_q[`PERIPH_SLOT_LSB-1:0] == `UART_REG_DATA)
      rdata = {24'b0, tx_byte};
  end

  // start, eight data bits lsb first, stop
  always_ff @(posedge CLK_CM3 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state    <= IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
    end
    else
    begin
      if (state != IDLE)
        baud_cnt <= baud_end ? '0 : baud_cnt + 1'b1;
      case (state)
        IDLE:
        begin
          tx <= 1'b1;
          if (start_tx)
          begin
            baud_cnt <= '0;
            tx       <= 1'b0;
            state    <= START;
          end
        end
        START:
        begin
          if (baud_end)
          begin
            tx      <= tx_byte[0];
            bit_cnt <= '0;
            state   <= DATA;
          end
        end
        DATA:
        begin
          if (baud_end)
          begin
            if (bit_cnt == 3'd7)
            begin
              tx    <= 1'b1;
              state <= STOP;
            end
            else
            begin
              tx      <= tx_byte[bit_cnt + 3'd1];
              bit_cnt <= bit_cnt + 3'd1;
            end
          end
        end
        STOP:
        begin
          if (baud_end)
            state <= IDLE;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  a_tx_idle_high : assert property (
    @(posedge CLK_CM3) disable iff (!arst_n)
    (state == IDLE) |-> tx
  );

endmodule

// File: vlog.f
+incdir+verilog
verilog/periph_pkg.sv
verilog/ahb_decoder.sv
verilog/seg7_scanner.sv
verilog/uart_tx.sv
verilog/periph_top.sv
verification/tb_periph.sv
